/* hw/stringAccel_cfg.svh */
// Build-wide sizes for the string accelerator
// Queue depth, register address width and bus data width
`ifndef STRINGACCEL_CFG_SVH
`define STRINGACCEL_CFG_SVH

// Slots in the operand A queue, kept a power of two
`define QUEUE_DEPTH 16

`define ADDR_WIDTH 3   // Word address into the register map

`define DATA_WIDTH 32  // Avalon data bus

`endif

/* hw/avalonPkg.sv */
// Avalon side types of the string accelerator
// Bus words, register map and control word layout
`default_nettype none
`include "stringAccel_cfg.svh"

package avalonPkg;

   typedef logic [`DATA_WIDTH-1:0] busData_t;   // One bus word
   typedef logic [`ADDR_WIDTH-1:0] busAddr_t;   // Register word address

   // Register map
   typedef enum logic [`ADDR_WIDTH-1:0] {
      regA       = 3'd0,   // Push on write, pop on read
      regB       = 3'd1,
      regControl = 3'd2,
      regResult  = 3'd3    // Read only
   } regAddr_e;

   // Control register as seen on the bus, bit 0 at the bottom
   typedef struct packed {
      logic [15:0] zero;     // Reads as zero
      logic [7:0]  count;    // Queue fill level, read only
      logic [2:0]  length;   // Bytes of B to copy
      logic [2:0]  index;    // First A byte to overwrite
      logic        go;       // Write 1 to start, reads 0
      logic        done;     // Sticky, read only
   } ctrlWord_t;

endpackage

`default_nettype wire

/* hw/stringPkg.sv */
// String engine types
// Characters, operand words, merge job and engine states
`default_nettype none

package stringPkg;

   // One character
   typedef logic [7:0] strByte_t;

   // Four characters, byte 0 in the top bits
   typedef strByte_t [0:3] strWord_t;

   // Byte position or byte count, may point past the word
   typedef logic [2:0] bytePos_t;

   // Everything the engine needs for one merge
   typedef struct packed {
      strWord_t a;        // Word taken from the queue
      strWord_t b;        // Source of the copied bytes
      bytePos_t index;    // First byte of A replaced
      bytePos_t length;   // Number of bytes replaced
   } mergeJob_t;

   // Engine FSM
   typedef enum logic {
      mergeIdle = 1'b0,
      mergeBusy = 1'b1    // Walking bytes 0 to 3
   } mergeState_e;

endpackage

`default_nettype wire

/* hw/stringRegs.sv */
// Avalon register block of the string accelerator
// Operand A queue, B and control registers, result capture and read-back
`timescale 1ns/1ps
`default_nettype none
`include "stringAccel_cfg.svh"

module stringRegs
   import avalonPkg::*, stringPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  busAddr_t  address,
   input  busData_t  writeData,
   input  logic      write,
   input  logic      read,
   input  logic      chipSelect,
   input  logic      busy,      // Engine working
   input  logic      finish,    // Result valid this cycle
   input  strWord_t  result,
   output busData_t  readData,  // One cycle after read
   output logic      start,
   output mergeJob_t job
);

   localparam int PtrWidth = $clog2(`QUEUE_DEPTH);
   localparam int CntWidth = $clog2(`QUEUE_DEPTH + 1);   // Must hold 0 to QUEUE_DEPTH

   busData_t            queue [`QUEUE_DEPTH];   // Operand A words
   logic [PtrWidth-1:0] inPtr;                   // Next free slot
   logic [PtrWidth-1:0] outPtr;                  // Oldest word
   logic [CntWidth-1:0] count;

   strWord_t  bReg;
   bytePos_t  indexReg;     // Last written index
   bytePos_t  lengthReg;    // Last written length
   strWord_t  resultReg;
   logic      done;

   logic      wrA, rdA, wrB, wrCtrl;
   logic      queueEmpty, queueFull;
   logic      pushA, popA, goAccept;
   ctrlWord_t ctrlIn, ctrlOut;

   // Address decode, one strobe per register access
   assign wrA    = chipSelect && write && (address == regA);
   assign rdA    = chipSelect && read  && (address == regA);
   assign wrB    = chipSelect && write && (address == regB);
   assign wrCtrl = chipSelect && write && (address == regControl);

   assign ctrlIn     = ctrlWord_t'(writeData);
   assign queueEmpty = (count == '0);
   assign queueFull  = (count == CntWidth'(`QUEUE_DEPTH));

   assign pushA = wrA && !queueFull;   // Write to a full queue is dropped
   // Start already in flight counts as busy, the engine has not seen it yet
   assign goAccept = wrCtrl && ctrlIn.go && !busy && !start;
   assign popA     = (rdA || goAccept) && !queueEmpty;

   // Queue pointers and fill level
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         inPtr  <= '0;
         outPtr <= '0;
         count  <= '0;
      end else begin
         if (pushA) inPtr <= inPtr + 1'b1;     // Wraps with the power of two depth
         if (popA) outPtr <= outPtr + 1'b1;
         count <= count + CntWidth'(pushA) - CntWidth'(popA);
      end
   end

   always_ff @(posedge clk) begin
      if (pushA) queue[inPtr] <= writeData;
   end

   // Host visible registers and sticky done
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bReg      <= '0;
         indexReg  <= '0;
         lengthReg <= '0;
         resultReg <= '0;
         done      <= 1'b0;
      end else begin
         if (wrB) bReg <= writeData;
         if (wrCtrl) begin               // Kept even when go is refused
            indexReg  <= ctrlIn.index;
            lengthReg <= ctrlIn.length;
         end
         if (finish) begin
            resultReg <= result;
            done      <= 1'b1;
         end else if (goAccept) begin
            done <= 1'b0;                 // New job in progress
         end
      end
   end

   // Start pulse, one cycle after the go write
   always_ff @(posedge clk or posedge reset) begin
      if (reset) start <= 1'b0;
      else       start <= goAccept;
   end

   // Job payload, sampled together with start
   always_ff @(posedge clk) begin
      if (goAccept) begin
         job.a      <= queueEmpty ? '0 : queue[outPtr];   // Empty queue merges into zero
         job.b      <= bReg;
         job.index  <= ctrlIn.index;
         job.length <= ctrlIn.length;
      end
   end

   // Control word for read-back, go always reads 0
   always_comb begin
      ctrlOut        = '0;
      ctrlOut.done   = done;
      ctrlOut.index  = indexReg;
      ctrlOut.length = lengthReg;
      ctrlOut.count  = 8'(count);
   end

   // Registered read mux
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readData <= '0;
      end else if (chipSelect && read) begin
         case (regAddr_e'(address))
            regA:       readData <= queueEmpty ? '0 : queue[outPtr];   // Pop
            regB:       readData <= bReg;
            regControl: readData <= ctrlOut;
            regResult:  readData <= resultReg;
            default:    readData <= '0;   // Unmapped
         endcase
      end
   end

   // A push into a full queue never raises the fill level past the depth
   assert property (@(posedge clk) disable iff (reset) count <= CntWidth'(`QUEUE_DEPTH));

   // The engine is idle whenever a start reaches it
   assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

/* hw/stringMerge.sv */
// Byte-serial merge engine
// Overwrites a window of A bytes with B bytes, one byte per cycle
`timescale 1ns/1ps
`default_nettype none

module stringMerge
   import stringPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      start,    // One cycle, only while idle
   input  mergeJob_t job,
   output logic      busy,
   output logic      finish,   // With the last byte
   output strWord_t  result
);

   mergeState_e state;
   bytePos_t    byteCnt;    // Byte being written
   mergeJob_t   jobReg;     // Latched on start
   strWord_t    work;       // Bytes 0 to byteCnt-1 already merged

   logic [3:0]  winEnd;     // index + length, up to 14
   logic        inWindow;
   logic [1:0]  bOffset;    // B byte feeding this position
   strByte_t    selByte;

   // Window of replaced positions is index to index+length-1
   assign winEnd   = {1'b0, jobReg.index} + {1'b0, jobReg.length};
   assign inWindow = (byteCnt >= jobReg.index) && ({1'b0, byteCnt} < winEnd);
   assign bOffset  = 2'(byteCnt - jobReg.index);   // Below 4 whenever inWindow holds

   assign selByte = inWindow ? jobReg.b[bOffset] : jobReg.a[byteCnt[1:0]];

   // Working word with the current byte dropped in
   always_comb begin
      result                 = work;
      result[byteCnt[1:0]]   = selByte;
   end

   assign busy   = (state == mergeBusy);
   assign finish = busy && (byteCnt == 3'd3);   // Last byte goes straight out

   // FSM and byte counter
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state   <= mergeIdle;
         byteCnt <= '0;
      end else begin
         case (state)
            mergeIdle: begin
               if (start) begin
                  state   <= mergeBusy;
                  byteCnt <= '0;
               end
            end
            mergeBusy: begin
               if (byteCnt == 3'd3) begin
                  state   <= mergeIdle;
                  byteCnt <= '0;
               end else begin
                  byteCnt <= byteCnt + 1'b1;
               end
            end
            default: state <= mergeIdle;
         endcase
      end
   end

   // Operand latch and byte write-back
   always_ff @(posedge clk) begin
      if (state == mergeIdle && start) begin
         jobReg <= job;
         work   <= job.a;
      end else if (busy) begin
         work <= result;   // Commit this cycle's byte
      end
   end

   // Finish arrives with the fourth byte, four cycles after the accepted start
   assert property (@(posedge clk) disable iff (reset)
      (state == mergeIdle && start) |-> ##4 finish);

   // Byte counter never leaves the word
   assert property (@(posedge clk) disable iff (reset) busy |-> byteCnt <= 3'd3);

endmodule

`default_nettype wire

/* hw/stringAccel.sv */
// String accelerator top level
// Avalon register block driving the byte merge engine
`timescale 1ns/1ps
`default_nettype none

module stringAccel
   import avalonPkg::*, stringPkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  busAddr_t address,
   input  busData_t writeData,
   input  logic     write,
   input  logic     read,
   input  logic     chipSelect,
   output busData_t readData
);

   logic      start, busy, finish;
   mergeJob_t job;      // Operands for the next merge
   strWord_t  result;   // Valid with finish

   stringRegs regs0 (
      .clk        (clk),
      .reset      (reset),
      .address    (address),
      .writeData  (writeData),
      .write      (write),
      .read       (read),
      .chipSelect (chipSelect),
      .busy       (busy),
      .finish     (finish),
      .result     (result),
      .readData   (readData),
      .start      (start),
      .job        (job)
   );

   stringMerge merge0 (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .job    (job),
      .busy   (busy),
      .finish (finish),
      .result (result)
   );

endmodule

`default_nettype wire

/* test/stringAccelTb.sv */
// Directed testbench of the string accelerator
// Avalon bus tasks, byte merge model and register checks
`timescale 1ns/1ps
`default_nettype none
`include "stringAccel_cfg.svh"

module stringAccelTb
   import avalonPkg::*;
();

   logic        clk;
   logic        reset;
   busAddr_t    address;
   busData_t    writeData;
   logic        write;
   logic        read;
   logic        chipSelect;
   busData_t    readData;

   stringAccel dut0 (
      .clk        (clk),
      .reset      (reset),
      .address    (address),
      .writeData  (writeData),
      .write      (write),
      .read       (read),
      .chipSelect (chipSelect),
      .readData   (readData)
   );

   always #20 clk = ~clk;   // 40 ns period

   task automatic checkEq(input string name, input busData_t got, input busData_t exp);
      if (got !== exp) begin
         $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   // One write, sampled by the DUT on the second edge
   task automatic busWrite(input busAddr_t addr, input busData_t data);
      @(posedge clk);
      #2;
      chipSelect = 1'b1;
      write      = 1'b1;
      address    = addr;
      writeData  = data;
      @(posedge clk);
      #2;
      chipSelect = 1'b0;
      write      = 1'b0;
   endtask

   task automatic busRead(input busAddr_t addr, output busData_t data);
      @(posedge clk);
      #2;
      chipSelect = 1'b1;
      read       = 1'b1;
      address    = addr;
      @(posedge clk);
      #2;
      data       = readData;   // Registered one cycle after read
      chipSelect = 1'b0;
      read       = 1'b0;
   endtask

   // Control word with go set, bits 4:2 index, 7:5 length
   function automatic busData_t ctrlGo(input logic [2:0] index, input logic [2:0] length);
      return {24'd0, length, index, 2'b10};
   endfunction

   // Byte k of A replaced by byte k-index of B inside the window, byte 0 on top
   function automatic busData_t mergeModel(input busData_t a, input busData_t b,
                                           input int index, input int length);
      busData_t res;
      res = a;
      for (int k = 0; k < 4; k++) begin
         if (k >= index && k < index + length)
            res[31-8*k -: 8] = b[31-8*(k-index) -: 8];
      end
      return res;
   endfunction

   task automatic checkCount(input int exp);
      busData_t rd;
      busRead(regControl, rd);
      checkEq("regControl.count", busData_t'(rd[15:8]), exp);
   endtask

   // Poll the done bit, give up after a bounded number of reads
   task automatic waitDone();
      busData_t rd;
      int       polls;
      rd    = '0;
      polls = 0;
      while (rd[0] !== 1'b1) begin
         if (polls == 40) begin
            $display("Timeout: done flag never set after a go write");
            $display("Done: errors found");
            $fatal(1);
         end
         busRead(regControl, rd);
         polls++;
      end
   endtask

   task automatic resetValues();
      busData_t rd;
      busRead(regControl, rd);
      checkEq("regControl", rd, '0);
      busRead(regB, rd);
      checkEq("regB", rd, '0);
      busRead(regResult, rd);
      checkEq("regResult", rd, '0);
   endtask

   task automatic queueOrder();
      busData_t words [3];
      busData_t rd;
      for (int i = 0; i < 3; i++) begin
         words[i] = $urandom;
         busWrite(regA, words[i]);
         checkCount(i + 1);
      end
      for (int i = 0; i < 3; i++) begin
         busRead(regA, rd);   // Pops
         checkEq("regA", rd, words[i]);
         checkCount(2 - i);
      end
      busRead(regA, rd);
      checkEq("regA empty", rd, '0);
      checkCount(0);
   endtask

   task automatic fullQueueDrop();
      busData_t words [`QUEUE_DEPTH+1];
      busData_t rd;
      for (int i = 0; i <= `QUEUE_DEPTH; i++) begin
         words[i] = $urandom;
         busWrite(regA, words[i]);   // Last one hits a full queue
      end
      checkCount(`QUEUE_DEPTH);
      for (int i = 0; i < `QUEUE_DEPTH; i++) begin
         busRead(regA, rd);
         checkEq("regA", rd, words[i]);
      end
      checkCount(0);
   endtask

   task automatic randomMerges();
      busData_t   a, b, rd;
      logic [2:0] index, length;
      for (int n = 0; n < 40; n++) begin
         a      = $urandom;
         b      = $urandom;
         index  = 3'($urandom % 8);
         length = 3'($urandom % 8);
         busWrite(regA, a);
         checkCount(1);
         busWrite(regB, b);
         busWrite(regControl, ctrlGo(index, length));
         waitDone();
         busRead(regResult, rd);
         checkEq("regResult", rd, mergeModel(a, b, index, length));
         busRead(regControl, rd);   // Done set, A word consumed, go reads 0
         checkEq("regControl", rd, {24'd0, length, index, 2'b01});
      end
   endtask

   task automatic goWhileBusy();
      busData_t a1, a2, b, rd;
      a1 = $urandom;
      a2 = $urandom;
      b  = $urandom;
      busWrite(regA, a1);
      busWrite(regA, a2);
      busWrite(regB, b);
      busWrite(regControl, ctrlGo(3'd1, 3'd2));
      busWrite(regControl, ctrlGo(3'd0, 3'd4));   // Lands while the engine runs
      waitDone();
      busRead(regResult, rd);
      checkEq("regResult", rd, mergeModel(a1, b, 1, 2));
      checkCount(1);
      busRead(regA, rd);
      checkEq("regA", rd, a2);
   endtask

   task automatic mergeEmptyQueue();
      busData_t b, rd;
      b = $urandom;
      checkCount(0);
      busWrite(regB, b);
      busWrite(regControl, ctrlGo(3'd2, 3'd3));
      waitDone();
      busRead(regResult, rd);
      checkEq("regResult", rd, mergeModel('0, b, 2, 3));
      checkCount(0);
   endtask

   initial begin
      void'($urandom(32'h15e2d1bf));
      clk        = 1'b0;
      reset      = 1'b1;
      address    = '0;
      writeData  = '0;
      write      = 1'b0;
      read       = 1'b0;
      chipSelect = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      resetValues();
      queueOrder();
      fullQueueDrop();
      randomMerges();
      goWhileBusy();
      mergeEmptyQueue();
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/avalonPkg.sv
hw/stringPkg.sv
hw/stringRegs.sv
hw/stringMerge.sv
hw/stringAccel.sv
test/stringAccelTb.sv

/* Makefile */
# Verilator build and run of the string accelerator testbench
VERILATOR ?= verilator
TOP       ?= stringAccelTb
RTL_TOP   ?= stringAccel
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
